//--- ch_est_tests.txt
// one case per line: v_shift, valid window length, six output pairs
// pair = s_h1 digit then s_h2 digit, first output first, 00 past the window
// mode 0
0 5 11 12 20 33 12 00
// mode 1
1 6 11 12 02 13 12 20
// mode 2
2 6 30 00 31 30 20 33
// shift 3 to 5 map onto the same three modes
3 5 11 12 20 33 12 00
4 6 11 12 02 13 12 20
5 6 30 00 31 30 20 33

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ch_est_ctrl
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
est_pkg.sv
interp_pkg.sv
pilot_mult_seq.sv
adder_sched.sv
out_sel_seq.sv
ch_est_ctrl.sv
tb_ch_est_ctrl.sv

//--- tb_ch_est_ctrl.sv
// ==============================
// testbench for the estimator control, cases from the tests file
// ==============================

`timescale 1ns/10ps

module tb_ch_est_ctrl;

    import est_pkg::*;
    import interp_pkg::*;

    localparam int num_cases  = 6;
    localparam int case_words = 8;
    localparam int wait_limit = 20;

    logic       clk;
    logic       rst;
    logic       demap_ready;
    logic       nrs_gen_ready;
    logic [2:0] v_shift;
    logic [3:0] col;
    logic [1:0] nrs_index_addr;
    logic       demap_read;
    logic       est_ack_nrs;
    logic       est_ack_demap;
    logic [3:0] rd_addr_nrs;
    logic       valid_eqlz;
    logic [1:0] addr_mem;
    logic       mult_mem_en;
    logic       avg_mem_en;
    logic       en_reg_e;
    logic       en_reg_2e;
    logic       en_reg_5e;
    logic [2:0] s1a;
    logic [2:0] s1b;
    logic [2:0] s2a;
    logic [2:0] s2b;
    logic [1:0] s_h1;
    logic [1:0] s_h2;
    logic       s_est;
    logic [1:0] shift;

    // per case: v_shift, window length, six {s_h1, s_h2} digit pairs
    logic [7:0] tests_mem [num_cases*case_words];
    // pilot columns in burst order
    logic [3:0] col_order [4];
    integer     seed;

    // stage 1 model counters
    logic [1:0] m_cnt;
    logic [1:0] m_col_idx;
    logic [1:0] m_nrs;
    logic [3:0] m_rd;

    ch_est_ctrl #(.nrs_addr_w(4)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t: %s, got %0h expected %0h", $time, what, got, exp));
        end
    endtask

    // one cycle with the given readies, returns at the falling edge
    task automatic run_cycle(input logic dr, input logic nr);
        @(posedge clk);
        #2;
        demap_ready   = dr;
        nrs_gen_ready = nr;
        @(negedge clk);
    endtask

    // v_shift 0/3 -> 0, 1/4 -> 1, else 2
    function automatic logic [1:0] mode_for(input logic [2:0] vs);
        if (vs == 3'd0 || vs == 3'd3) return 2'd0;
        if (vs == 3'd1 || vs == 3'd4) return 2'd1;
        return 2'd2;
    endfunction

    task automatic check_reset();
        check_eq(32'(demap_read), 32'd0, "demap_read after reset");
        check_eq(32'(est_ack_nrs), 32'd0, "est_ack_nrs after reset");
        check_eq(32'(est_ack_demap), 32'd0, "est_ack_demap after reset");
        check_eq(32'(mult_mem_en | avg_mem_en), 32'd0, "memory enables after reset");
        check_eq(32'({en_reg_e, en_reg_2e, en_reg_5e}), 32'd0, "register enables after reset");
        check_eq(32'(valid_eqlz), 32'd0, "valid_eqlz after reset");
        check_eq(32'({s1a, s1b, s2a, s2b}), 32'hfff, "adder selects after reset");
        check_eq(32'(col), 32'd5, "col after reset");
        check_eq(32'(rd_addr_nrs), 32'd0, "rd_addr_nrs after reset");
    endtask

    // random gap with at least one ready low, nothing may start
    task automatic ready_gap();
        int         n;
        logic [1:0] rdy;
        n = ($random(seed) & 3) + 1;
        repeat (n) begin
            rdy = 2'($random(seed));
            if (rdy == 2'b11) begin
                rdy = 2'b01;
            end
            run_cycle(rdy[0], rdy[1]);
            check_eq(32'(demap_read | est_ack_nrs), 32'd0, "read or ack during ready gap");
            check_eq(32'(mult_mem_en | avg_mem_en), 32'd0, "memory enable during ready gap");
        end
    endtask

    // request one burst, check both cycles against the model
    task automatic run_burst(input int idx);
        int   n;
        logic acc;
        acc = (idx >= 2);
        n   = 0;
        run_cycle(1'b1, 1'b1);
        while (!demap_read) begin
            if (n == wait_limit) begin
                abort_run("timeout while waiting for a burst to start");
            end
            n++;
            run_cycle(1'b1, 1'b1);
        end
        // idle on the request cycle, burst on the next
        check_eq(32'(n), 32'd1, "burst start latency");
        for (int k = 0; k < 2; k++) begin
            if (k == 1) begin
                run_cycle(1'b0, 1'b0);
            end
            check_eq(32'(mult_mem_en), 32'(!acc), "mult_mem_en in burst");
            check_eq(32'(avg_mem_en), 32'(acc), "avg_mem_en in burst");
            check_eq(32'(demap_read & est_ack_nrs), 32'd1, "read and ack in burst");
            check_eq(32'(addr_mem), 32'(m_cnt), "addr_mem");
            check_eq(32'(col), 32'(col_order[m_col_idx]), "pilot column");
            check_eq(32'(nrs_index_addr), 32'(m_nrs), "nrs_index_addr");
            check_eq(32'(rd_addr_nrs), 32'(m_rd), "rd_addr_nrs");
            check_eq(32'(est_ack_demap), 32'(idx == 3 && k == 0), "est_ack_demap pulse");
            // adder 2 leaves idle right after the start pulse
            if (idx == 3 && k == 0) begin
                check_eq(32'(s2a), 32'd7, "s2a before start");
            end
            if (idx == 3 && k == 1) begin
                check_eq(32'(s2a != 3'd7 && s2b != 3'd7), 32'd1, "adder 2 selects after start");
            end
            if (m_cnt[0]) begin
                m_col_idx = m_col_idx + 2'd1;
            end
            m_cnt = m_cnt + 2'd1;
            m_nrs = m_nrs + 2'd1;
            m_rd  = m_rd + 4'd2;
        end
    endtask

    // ============================
    // one case: frame of four bursts, then the valid window
    // ============================

    task automatic run_case(input int c);
        int         base;
        int         len;
        int         n;
        logic [1:0] exp_mode;
        base     = c * case_words;
        len      = int'(tests_mem[base+1]);
        exp_mode = mode_for(tests_mem[base][2:0]);
        @(posedge clk);
        #2;
        v_shift       = tests_mem[base][2:0];
        demap_ready   = 1'b0;
        nrs_gen_ready = 1'b0;
        @(negedge clk);
        check_eq(32'(shift), 32'(exp_mode), "decoded shift mode");
        check_eq(32'(s_est), 32'(exp_mode[0]), "s_est");
        for (int b = 0; b < 4; b++) begin
            ready_gap();
            run_burst(b);
        end
        n = 0;
        while (!valid_eqlz) begin
            if (n == wait_limit) begin
                abort_run("timeout while waiting for valid_eqlz to rise");
            end
            n++;
            run_cycle(1'b0, 1'b0);
        end
        n = 0;
        // one extra pass shows a window that runs long
        while (valid_eqlz && n <= len) begin
            if (n < len) begin
                check_eq(32'(s_h1), 32'(tests_mem[base+2+n][7:4]), "s_h1 in window");
                check_eq(32'(s_h2), 32'(tests_mem[base+2+n][3:0]), "s_h2 in window");
            end
            check_eq(32'(s_est), 32'(exp_mode[0]), "s_est in window");
            n++;
            run_cycle(1'b0, 1'b0);
        end
        check_eq(32'(n), 32'(len), "valid_eqlz window length");
    endtask

    initial begin
        seed          = 32'h10ef_1173;
        rst           = 1'b0;
        demap_ready   = 1'b0;
        nrs_gen_ready = 1'b0;
        v_shift       = 3'd0;
        m_cnt         = 2'd0;
        m_col_idx     = 2'd0;
        m_nrs         = 2'd0;
        m_rd          = 4'd0;
        col_order     = '{4'd5, 4'd6, 4'd12, 4'd13};
        $readmemh("ch_est_tests.txt", tests_mem);
        if ($isunknown(tests_mem[num_cases*case_words-1])) begin
            abort_run("tests file ch_est_tests.txt is missing or too short");
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b1;
        @(negedge clk);
        check_reset();
        for (int c = 0; c < num_cases; c++) begin
            run_case(c);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- ch_est_ctrl.sv
// ==============================
// channel estimator control, three-stage top level
// ==============================

`timescale 1ns/10ps

module ch_est_ctrl #(
    parameter int nrs_addr_w = est_pkg::nrs_addr_w_default
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  demap_ready,
    input  logic                  nrs_gen_ready,
    input  logic [2:0]            v_shift,
    // demapper side
    output logic [3:0]            col,
    output logic [1:0]            nrs_index_addr,
    output logic                  demap_read,
    output logic                  est_ack_nrs,
    output logic                  est_ack_demap,
    output logic [nrs_addr_w-1:0] rd_addr_nrs,
    output logic                  valid_eqlz,
    // multiply and average memories
    output logic [1:0]            addr_mem,
    output logic                  mult_mem_en,
    output logic                  avg_mem_en,
    // interpolation datapath
    output logic                  en_reg_e,
    output logic                  en_reg_2e,
    output logic                  en_reg_5e,
    output logic [2:0]            s1a,
    output logic [2:0]            s1b,
    output logic [2:0]            s2a,
    output logic [2:0]            s2b,
    output logic [1:0]            s_h1,
    output logic [1:0]            s_h2,
    output logic                  s_est,
    output logic [1:0]            shift
);

    import interp_pkg::*;

    shift_mode_t mode;
    logic        sel_load, out_open, out_close;

    assign shift = mode;

    // est_ack_demap doubles as the stage 1 to stage 2 start pulse
    pilot_mult_seq #(.nrs_addr_w(nrs_addr_w)) i_pilot_mult_seq (
        .clk(clk), .rst(rst), .demap_ready(demap_ready), .nrs_gen_ready(nrs_gen_ready),
        .col(col), .nrs_index_addr(nrs_index_addr), .rd_addr_nrs(rd_addr_nrs),
        .demap_read(demap_read), .est_ack_nrs(est_ack_nrs), .mult_mem_en(mult_mem_en),
        .avg_mem_en(avg_mem_en), .est_start(est_ack_demap), .addr_mem(addr_mem)
    );

    adder_sched i_adder_sched (
        .clk(clk), .rst(rst), .est_start(est_ack_demap), .v_shift(v_shift), .mode(mode),
        .s1a(s1a), .s1b(s1b), .s2a(s2a), .s2b(s2b),
        .en_reg_e(en_reg_e), .en_reg_2e(en_reg_2e), .en_reg_5e(en_reg_5e),
        .sel_load(sel_load), .out_open(out_open), .out_close(out_close)
    );

    out_sel_seq i_out_sel_seq (
        .clk(clk), .rst(rst), .mode(mode), .sel_load(sel_load), .out_open(out_open),
        .out_close(out_close), .s_h1(s_h1), .s_h2(s_h2), .s_est(s_est),
        .valid_eqlz(valid_eqlz)
    );

endmodule

//--- out_sel_seq.sv
// ==============================
// stage 3: output select shift registers, valid flag
// ==============================

`timescale 1ns/10ps

module out_sel_seq (
    input  logic                    clk,
    input  logic                    rst,
    input  interp_pkg::shift_mode_t mode,
    input  logic                    sel_load,
    input  logic                    out_open,
    input  logic                    out_close,
    output interp_pkg::out_sel_t    s_h1,
    output interp_pkg::out_sel_t    s_h2,
    output logic                    s_est,
    output logic                    valid_eqlz
);

    import interp_pkg::*;

    out_seq_t h1_sr, h2_sr;

    // window opens and closes one cycle after the pulses
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_eqlz <= 1'b0;
        end else if (out_close) begin
            valid_eqlz <= 1'b0;
        end else if (out_open) begin
            valid_eqlz <= 1'b1;
        end
    end

    // load mode tables, then one pair per cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            h1_sr <= '0;
            h2_sr <= '0;
        end else if (sel_load) begin
            h1_sr <= h1_seq[mode];
            h2_sr <= h2_seq[mode];
        end else begin
            h1_sr <= h1_sr >> 2;
            h2_sr <= h2_sr >> 2;
        end
    end

    assign s_h1 = h1_sr[1:0];
    assign s_h2 = h2_sr[1:0];
    // m1 swaps estimate pairs between the two output muxes
    assign s_est = mode[0];

    a_pulse_excl : assert property (@(posedge clk) disable iff (!rst)
        !(out_open && out_close));

endmodule

//--- adder_sched.sv
// ==============================
// stage 2: shift mode decode, two interpolation adder FSMs
// ==============================

`timescale 1ns/10ps

module adder_sched (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    est_start,
    input  logic [2:0]              v_shift,
    output interp_pkg::shift_mode_t mode,
    output interp_pkg::add_sel_t    s1a,
    output interp_pkg::add_sel_t    s1b,
    output interp_pkg::add_sel_t    s2a,
    output interp_pkg::add_sel_t    s2b,
    output logic                    en_reg_e,
    output logic                    en_reg_2e,
    output logic                    en_reg_5e,
    output logic                    sel_load,
    output logic                    out_open,
    output logic                    out_close
);

    import interp_pkg::*;

    add1_state_t a1_state, a1_next;
    add2_state_t a2_state, a2_next;
    logic        go_1, go_2;
    logic        a1_wait, a2_wait;
    logic        a1_wake;

    always_comb begin
        case (v_shift)
            3'd0, 3'd3: mode = shift_m0;
            3'd1, 3'd4: mode = shift_m1;
            default:    mode = shift_m2;
        endcase
    end

    // adder 1 starts on est_start in m0, otherwise trails adder 2
    always_comb begin
        case (mode)
            shift_m0: a1_wake = est_start;
            shift_m1: a1_wake = (a2_state == a2_4e1_e3);
            default:  a1_wake = (a2_state == a2_5e1);
        endcase
    end

    // ============================
    // state registers, go delays
    // ============================

    // a go wait holds its state exactly two cycles
    assign a1_wait = (mode != shift_m1 && a1_state == a1_e2_2e3) || a1_state == a1_5e1_2e3;
    assign a2_wait = (mode != shift_m0) && (a2_state == a2_2e1_e3);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            a1_state <= a1_idle;
            a2_state <= a2_idle;
            go_1     <= 1'b0;
            go_2     <= 1'b0;
        end else begin
            a1_state <= a1_next;
            a2_state <= a2_next;
            go_1     <= !go_1 && a1_wait;
            go_2     <= !go_2 && a2_wait;
        end
    end

    // ============================
    // next state
    // ============================

    always_comb begin
        case (a1_state)
            a1_idle:    a1_next = a1_wake ? a1_first[mode] : a1_idle;
            a1_e2:      a1_next = (mode == shift_m1) ? a1_e2_2e4 : a1_2e2;
            a1_2e2:     a1_next = a1_e2_2e3;
            a1_e2_2e3: begin
                // no wait here in m1
                if (mode == shift_m1) begin
                    a1_next = a1_e2;
                end else begin
                    a1_next = go_1 ? a1_e2_2e4 : a1_e2_2e3;
                end
            end
            a1_e2_2e4:  a1_next = (mode == shift_m0) ? a1_2e2_5e4 : a1_idle;
            a1_2e2_5e4: a1_next = a1_idle;
            a1_2e3_e1:  a1_next = a1_e2_2e3;
            a1_2e3:     a1_next = a1_5e1_2e3;
            a1_5e1_2e3: a1_next = go_1 ? a1_2e3_e1 : a1_5e1_2e3;
            default:    a1_next = a1_idle;
        endcase
    end

    always_comb begin
        case (a2_state)
            a2_idle:   a2_next = est_start ? a2_first[mode] : a2_idle;
            a2_2e1_e3: begin
                if (mode == shift_m0) begin
                    a2_next = a2_e1_2e3;
                end else begin
                    a2_next = go_2 ? a2_2e2_e3 : a2_2e1_e3;
                end
            end
            a2_e1_2e3: a2_next = a2_2e2_e3;
            a2_2e2_e3: a2_next = a2_2e2_e4;
            // schedule tail differs per mode
            a2_2e2_e4: a2_next = (mode == shift_m0) ? a2_5e4 :
                                 (mode == shift_m1) ? a2_4e4_e2 : a2_idle;
            a2_5e4:    a2_next = a2_4e4_e2;
            a2_e3:     a2_next = a2_4e1_e3;
            a2_4e1_e3: a2_next = a2_2e1_e3;
            a2_5e1:    a2_next = a2_e3;
            default:   a2_next = a2_idle;
        endcase
    end

    // ============================
    // selects, enables, stage 3 pulses
    // ============================

    assign {s1a, s1b} = a1_sel[a1_state];
    assign {s2a, s2b} = a2_sel[a2_state];

    // negated single, negated double, five-times estimate registers
    assign en_reg_e  = (a1_state == a1_e2) || (mode == shift_m2 && a2_state == a2_e3);
    assign en_reg_2e = (a1_state == a1_2e2) || (a1_state == a1_2e3) ||
                       (mode == shift_m1 && a2_state == a2_e3);
    assign en_reg_5e = (a2_state == a2_5e4) || (a2_state == a2_5e1);

    // first output lands the cycle after, same cycle valid rises
    assign sel_load  = (mode == shift_m0 && a1_state == a1_e2) || (a2_state == a2_e3);
    assign out_open  = sel_load;
    assign out_close = (mode != shift_m2 && a2_state == a2_4e4_e2) ||
                       (mode == shift_m2 && a1_state == a1_e2_2e4);

    a_state_legal : assert property (@(posedge clk) disable iff (!rst)
        a1_state inside {a1_idle, a1_e2_2e3, a1_e2, a1_2e2, a1_e2_2e4, a1_2e2_5e4,
                         a1_2e3_e1, a1_2e3, a1_5e1_2e3} &&
        a2_state inside {a2_idle, a2_2e1_e3, a2_2e2_e3, a2_e1_2e3, a2_2e2_e4, a2_5e4,
                         a2_4e4_e2, a2_e3, a2_4e1_e3, a2_5e1});

    // burst spacing in stage 1 must cover the longest schedule
    a_start_idle : assert property (@(posedge clk) disable iff (!rst)
        est_start |-> a2_state == a2_idle);

endmodule

//--- pilot_mult_seq.sv
// ==============================
// stage 1: store/accumulate burst FSM, pilot and memory addresses
// ==============================

`timescale 1ns/10ps

module pilot_mult_seq #(
    parameter int nrs_addr_w = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  demap_ready,
    input  logic                  nrs_gen_ready,
    output est_pkg::col_t         col,
    output logic [1:0]            nrs_index_addr,
    output logic [nrs_addr_w-1:0] rd_addr_nrs,
    output logic                  demap_read,
    output logic                  est_ack_nrs,
    output logic                  mult_mem_en,
    output logic                  avg_mem_en,
    output logic                  est_start,
    output est_pkg::burst_cnt_t   addr_mem
);

    import est_pkg::*;

    mult_state_t state, state_next;
    burst_cnt_t  cnt;
    burst_cnt_t  col_idx;
    logic        first_slot;
    logic        busy;

    // ============================
    // burst FSM
    // ============================

    // burst ends on odd count, so every burst is two cycles
    always_comb begin
        state_next = state;
        case (state)
            mult_idle: begin
                if (demap_ready && nrs_gen_ready) begin
                    state_next = first_slot ? mult_store : mult_acc;
                end
            end
            mult_store, mult_acc: begin
                if (cnt[0]) begin
                    state_next = mult_idle;
                end
            end
            default: state_next = mult_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state          <= mult_idle;
            cnt            <= '0;
            col_idx        <= '0;
            nrs_index_addr <= '0;
            rd_addr_nrs    <= '0;
            first_slot     <= 1'b1;
        end else begin
            state <= state_next;
            if (busy) begin
                cnt            <= cnt + 2'd1;
                nrs_index_addr <= nrs_index_addr + 2'd1;
                // two NRS words per pilot
                rd_addr_nrs    <= rd_addr_nrs + nrs_addr_w'(2);
                // next pilot column after each odd count
                if (cnt[0]) begin
                    col_idx <= col_idx + 2'd1;
                end
                // second burst of a slot done, swap store/accumulate
                if (cnt == 2'd3) begin
                    first_slot <= !first_slot;
                end
            end
        end
    end

    // ============================
    // outputs
    // ============================

    assign mult_mem_en = (state == mult_store);
    assign avg_mem_en  = (state == mult_acc);
    assign busy        = mult_mem_en || avg_mem_en;
    assign demap_read  = busy;
    assign est_ack_nrs = busy;
    assign addr_mem    = cnt;
    assign col         = pilot_col[col_idx];
    // third averaged estimate written on this cycle
    assign est_start   = avg_mem_en && (cnt == 2'd2);

    a_mem_en_excl : assert property (@(posedge clk) disable iff (!rst)
        !(mult_mem_en && avg_mem_en));

    // start pulse sits inside the second accumulate burst
    a_start_in_acc : assert property (@(posedge clk) disable iff (!rst)
        est_start |-> avg_mem_en ##1 (avg_mem_en && addr_mem == 2'd3));

endmodule

//--- interp_pkg.sv
// ==============================
// shift modes, adder FSM states, adder and output select tables
// ==============================

package interp_pkg;

    // v_shift 0/3 -> m0, 1/4 -> m1, the rest -> m2
    typedef enum logic [1:0] {
        shift_m0 = 2'd0,
        shift_m1 = 2'd1,
        shift_m2 = 2'd2
    } shift_mode_t;

    // ============================
    // adder FSM states
    // ============================

    // adder 1, each named after the term it combines
    typedef enum logic [3:0] {
        a1_idle    = 4'b0000,
        a1_e2_2e3  = 4'b0001,
        a1_e2      = 4'b0010,
        a1_2e2     = 4'b0011,
        a1_e2_2e4  = 4'b0100,
        a1_2e2_5e4 = 4'b0101,
        a1_2e3_e1  = 4'b1000,
        a1_2e3     = 4'b1100,
        a1_5e1_2e3 = 4'b1110
    } add1_state_t;

    // adder 2
    typedef enum logic [3:0] {
        a2_idle   = 4'b0000,
        a2_2e1_e3 = 4'b0001,
        a2_2e2_e3 = 4'b0010,
        a2_e1_2e3 = 4'b0011,
        a2_2e2_e4 = 4'b0100,
        a2_5e4    = 4'b0101,
        a2_4e4_e2 = 4'b0111,
        a2_e3     = 4'b1000,
        a2_4e1_e3 = 4'b1010,
        a2_5e1    = 4'b1011
    } add2_state_t;

    // first state out of idle, per mode
    localparam add1_state_t a1_first [3] = '{a1_e2, a1_2e3_e1, a1_2e3};
    localparam add2_state_t a2_first [3] = '{a2_2e1_e3, a2_e3, a2_5e1};

    // ============================
    // select codes
    // ============================

    typedef logic [2:0] add_sel_t;
    localparam add_sel_t add_sel_idle = 3'd7;

    // {a, b} select pairs per state, octal digit per select
    localparam add_sel_t [1:0] a1_sel [16] = '{
        a1_e2: 6'o00, a1_2e2: 6'o10, a1_e2_2e3: 6'o31, a1_e2_2e4: 6'o33,
        a1_2e2_5e4: 6'o22, a1_2e3_e1: 6'o66, a1_2e3: 6'o40, a1_5e1_2e3: 6'o54,
        default: {add_sel_idle, add_sel_idle}
    };
    localparam add_sel_t [1:0] a2_sel [16] = '{
        a2_2e1_e3: 6'o00, a2_e1_2e3: 6'o11, a2_2e2_e3: 6'o30, a2_2e2_e4: 6'o33,
        a2_5e4: 6'o23, a2_4e4_e2: 6'o22, a2_e3: 6'o66, a2_4e1_e3: 6'o44,
        a2_5e1: 6'o14, default: {add_sel_idle, add_sel_idle}
    };

    typedef logic [1:0] out_sel_t;
    typedef logic [11:0] out_seq_t;

    // output mux sequences, low pair first; m0 only fills 10 bits
    localparam out_seq_t h1_seq [3] = '{12'b00_01_11_10_01_01,
                                        12'b10_01_01_00_01_01,
                                        12'b11_10_11_11_00_11};
    localparam out_seq_t h2_seq [3] = '{12'b00_10_11_00_10_01,
                                        12'b00_10_11_10_10_01,
                                        12'b11_00_00_01_00_00};

endpackage

//--- est_pkg.sv
// ==============================
// pilot columns, burst and address widths, multiply FSM states
// ==============================

package est_pkg;

    // default NRS read address width
    localparam int nrs_addr_w_default = 4;

    // pilot cycle count, doubles as multiply memory address
    typedef logic [1:0] burst_cnt_t;

    // demapper column index
    typedef logic [3:0] col_t;

    // reference-signal columns of one subframe, in burst order
    localparam col_t pilot_col [4] = '{4'd5, 4'd6, 4'd12, 4'd13};

    // store writes the products, accumulate adds the second slot into them
    typedef enum logic [1:0] {
        mult_idle  = 2'b00,
        mult_store = 2'b01,
        mult_acc   = 2'b11
    } mult_state_t;

endpackage
